// File: flist.f
+incdir+hw
hw/juice_link_pkg.sv
hw/hpsdr_frame_pkg.sv
hw/byte_link_if.sv
hw/ftdi_phy.sv
hw/ds_frame_parser.sv
hw/us_frame_builder.sv
hw/juice_core.sv
testbench/tb_juice_core.sv

// File: Makefile
TOP = tb_juice_core

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// File: testbench/tb_juice_core.sv
// Self-checking testbench for juice_core with a FT245 FIFO chip model
// Run stays set after the third good frame, so every upstream C0 echoes that command
`timescale 1ns/100ps
`default_nettype none
`include "juice_settings.svh"

module tb_juice_core;
  import juice_link_pkg::*;
  import hpsdr_frame_pkg::*;

  localparam int FB          = `JUICE_FRAME_BYTES;
  localparam int N_DS_FRAMES = 6;
  localparam int N_US_FRAMES = 3;
  localparam int CYCLE_LIMIT = 4 * (N_DS_FRAMES + N_US_FRAMES) * FB + 2000;

  logic        clk = 1'b0;
  logic        reset;
  logic        rxf_empty_i;
  logic        txf_full_i;
  byte_t       data_i;
  byte_t       data_o;
  logic        data_oe_o, oe_n_o, rd_n_o, wr_n_o, siwu_n_o;
  cmd_addr_t   cmd_addr_o;
  cmd_data_t   cmd_data_o;
  logic        cmd_ptt_o, cmd_valid_o, run_o;
  tx_iq_t      tx_iq_o;
  logic        tx_iq_valid_o, tx_iq_ready_i;
  rx_iq_t      rx_iq_i;
  logic        rx_iq_valid_i, rx_iq_ready_o;

  // Scoreboards built from the frames sent
  byte_t       host_q [$];
  logic [38:0] cmd_q [$];
  tx_iq_t      iq_q [$];
  int unsigned rng = 32'haf1a_ed5b;
  int          cyc = 0;
  int          cap_cnt = 0;
  int          smp_idx = 0;
  logic        exp_run = 1'b0;
  logic        run_seen = 1'b0;
  logic        feeding = 1'b0;
  logic        wr_last;

  juice_core dut0 (.*);

  always #5 clk = ~clk;

  function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic rx_iq_t rx_sample_for(input int n);
    return {8'hC3, n[15:0], 8'h3C ^ n[7:0], ~n[15:0]};
  endfunction

  // Upstream byte at stream index idx, from the protocol-1 layout
  function automatic byte_t expected_us_byte(input int idx);
    int     f;
    int     p;
    int     b;
    rx_iq_t smp;
    f = idx / FB;
    p = idx % FB;
    b = (p - 8) % 8;
    smp = rx_sample_for(f * `JUICE_SLOTS + (p - 8) / 8);
    if (p < 3)
      return `JUICE_SYNC_BYTE;
    else if (p == 3)
      return {1'b0, `JUICE_RUN_ADDR, 1'b1};
    else if (p < 8)
      return byte_t'(f >> (8 * (7 - p)));
    else if (b >= 6)
      return 8'h00;
    return smp[47 - 8*b -: 8];
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic report_err(input string name, input logic [63:0] got, input logic [63:0] exp);
    abort_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // Queue one host frame; a bad frame has a broken sync and no 7F elsewhere
  task automatic add_frame(input cmd_addr_t a, input logic p, input cmd_data_t d, input bit bad);
    byte_t fr [FB];
    for (int i = 0; i < FB; i++)
    begin
      rng = lcg_next(rng);
      if (i < 3)
        fr[i] = `JUICE_SYNC_BYTE;
      else if (i == 3)
        fr[i] = {1'b0, a, p};
      else if (i < 8)
        fr[i] = d[8*(7-i) +: 8];
      else
        fr[i] = rng[23:16];
      if (bad && (i == 1))
        fr[i] = 8'h00;
      else if (bad && (i >= 3))
        fr[i] = rng[23:16] & 8'h3F;
      host_q.push_back(fr[i]);
    end
    if (!bad)
    begin
      cmd_q.push_back({a, p, d});
      for (int s = 0; s < `JUICE_SLOTS; s++)
        iq_q.push_back({fr[12+8*s], fr[13+8*s], fr[14+8*s], fr[15+8*s]});
    end
  endtask

  // ----------------------------------------
  // Chip model and stimulus, falling edge
  // ----------------------------------------
  always @(negedge clk)
  begin
    rng = lcg_next(rng);
    rxf_empty_i   = !feeding || (host_q.size() == 0) || (rng[7:5] == 3'd0);
    data_i        = (host_q.size() != 0) ? host_q[0] : 8'h00;
    txf_full_i    = (rng[12:10] == 3'd0);
    tx_iq_ready_i = (rng[17:16] != 2'd0);
    rx_iq_valid_i = (rng[20:19] != 2'd0);
    rx_iq_i       = rx_sample_for(smp_idx);
  end

  assign wr_last = !wr_n_o && !txf_full_i && (cap_cnt % FB == FB - 1);

  // ----------------------------------------
  // Transfers and scoreboard checks
  // ----------------------------------------
  always @(posedge clk)
  begin
    cyc = cyc + 1;
    if (cyc >= CYCLE_LIMIT)
      abort_run("Timeout: frames did not complete within the cycle limit");
    if (!reset)
    begin
      if (!rd_n_o && !rxf_empty_i)
        void'(host_q.pop_front());
      if (!wr_n_o && !txf_full_i)
      begin
        assert (data_o == expected_us_byte(cap_cnt))
          else report_err("data_o", data_o, expected_us_byte(cap_cnt));
        cap_cnt = cap_cnt + 1;
      end
      if (rx_iq_valid_i && rx_iq_ready_o)
        smp_idx = smp_idx + 1;
      if (cmd_valid_o)
      begin
        if (cmd_q.size() == 0)
          abort_run("Command decoded with no good frame pending");
        assert (cmd_addr_o == cmd_q[0][38:33])
          else report_err("cmd_addr_o", cmd_addr_o, cmd_q[0][38:33]);
        assert (cmd_ptt_o == cmd_q[0][32])
          else report_err("cmd_ptt_o", cmd_ptt_o, cmd_q[0][32]);
        assert (cmd_data_o == cmd_q[0][31:0])
          else report_err("cmd_data_o", cmd_data_o, cmd_q[0][31:0]);
        if (cmd_q[0][38:33] == `JUICE_RUN_ADDR)
          exp_run = cmd_q[0][0];
        void'(cmd_q.pop_front());
      end
      if (tx_iq_valid_o && tx_iq_ready_i)
      begin
        if (iq_q.size() == 0)
          abort_run("Transmit I/Q word with no slot pending");
        assert (tx_iq_o == iq_q[0])
          else report_err("tx_iq_o", tx_iq_o, iq_q[0]);
        void'(iq_q.pop_front());
      end
      assert (run_o == exp_run)
        else report_err("run_o", run_o, exp_run);
      if (run_o)
        run_seen = 1'b1;
    end
  end

  // ----------------------------------------
  // Pin protocol
  // ----------------------------------------
  a_quiet: assert property (@(posedge clk) (cyc > 0) && !feeding |->
    rd_n_o && oe_n_o && wr_n_o && siwu_n_o && !data_oe_o && !cmd_valid_o &&
    !tx_iq_valid_o && !rx_iq_ready_o && !run_o)
    else abort_run("Control output active before any byte moved");
  a_rd_wr: assert property (@(posedge clk) disable iff (reset) rd_n_o || wr_n_o)
    else abort_run("Read and write strobes low together");
  a_oe_wr: assert property (@(posedge clk) disable iff (reset) data_oe_o |-> !wr_n_o)
    else abort_run("Data output enabled without a write");
  a_rd_oe: assert property (@(posedge clk) disable iff (reset) !rd_n_o |-> !oe_n_o)
    else abort_run("Read strobe without output enable");
  a_no_wr: assert property (@(posedge clk) disable iff (reset) !run_seen |-> wr_n_o)
    else abort_run("Upstream write before run was set");
  a_siwu_after: assert property (@(posedge clk) disable iff (reset) wr_last |=> !siwu_n_o)
    else abort_run("No send-immediate pulse after the last frame byte");
  a_siwu_only: assert property (@(posedge clk) disable iff (reset) !siwu_n_o |-> $past(wr_last))
    else abort_run("Send-immediate pulse not after a last frame byte");

  initial
  begin
    reset         = 1'b1;
    rxf_empty_i   = 1'b1;
    txf_full_i    = 1'b0;
    data_i        = 8'h00;
    tx_iq_ready_i = 1'b0;
    rx_iq_i       = '0;
    rx_iq_valid_i = 1'b0;
    // Run address with bit 0 clear, then another address with bit 0 set
    add_frame(`JUICE_RUN_ADDR, 1'b0, lcg_next(rng) & 32'hFFFF_FFFE, 1'b0);
    add_frame(6'h12, 1'b0, 32'h0, 1'b1);
    add_frame(6'h05, 1'b1, lcg_next(rng + 1) | 32'h1, 1'b0);
    for (int i = 0; i < N_DS_FRAMES - 3; i++)
      add_frame(`JUICE_RUN_ADDR, 1'b1, lcg_next(rng + i) | 32'h1, 1'b0);
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    repeat (8) @(posedge clk);
    feeding = 1'b1;
    while (!((host_q.size() == 0) && (cmd_q.size() == 0) && (iq_q.size() == 0) &&
             (cap_cnt >= N_US_FRAMES * FB)))
      @(negedge clk);
    repeat (4) @(posedge clk);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/juice_core.sv
// Host-link top level on a single clock
// Data pins are split in, out and enable; the tristate is in the board wrapper
`timescale 1ns/100ps
`default_nettype none

module juice_core (
  input  wire                        clk,
  input  wire                        reset,
  // FT245 synchronous FIFO pins
  input  wire                        rxf_empty_i,
  input  wire                        txf_full_i,
  input  wire juice_link_pkg::byte_t data_i,
  output juice_link_pkg::byte_t      data_o,
  output logic                       data_oe_o,
  output logic                       oe_n_o,
  output logic                       rd_n_o,
  output logic                       wr_n_o,
  output logic                       siwu_n_o,
  // Register commands
  output hpsdr_frame_pkg::cmd_addr_t cmd_addr_o,
  output hpsdr_frame_pkg::cmd_data_t cmd_data_o,
  output logic                       cmd_ptt_o,
  output logic                       cmd_valid_o,
  output logic                       run_o,
  // Transmit samples
  output hpsdr_frame_pkg::tx_iq_t    tx_iq_o,
  output logic                       tx_iq_valid_o,
  input  wire                        tx_iq_ready_i,
  // Receive samples
  input  wire hpsdr_frame_pkg::rx_iq_t rx_iq_i,
  input  wire                        rx_iq_valid_i,
  output logic                       rx_iq_ready_o
);

  byte_link_if ds_link ();
  byte_link_if us_link ();

  ftdi_phy phy0 (
    .clk         (clk),
    .reset       (reset),
    .rxf_empty_i (rxf_empty_i),
    .txf_full_i  (txf_full_i),
    .data_i      (data_i),
    .data_o      (data_o),
    .data_oe_o   (data_oe_o),
    .oe_n_o      (oe_n_o),
    .rd_n_o      (rd_n_o),
    .wr_n_o      (wr_n_o),
    .siwu_n_o    (siwu_n_o),
    .ds_o        (ds_link.source),
    .us_i        (us_link.sink)
  );

  ds_frame_parser parser0 (
    .clk           (clk),
    .reset         (reset),
    .link_i        (ds_link.sink),
    .cmd_addr_o    (cmd_addr_o),
    .cmd_data_o    (cmd_data_o),
    .cmd_ptt_o     (cmd_ptt_o),
    .cmd_valid_o   (cmd_valid_o),
    .run_o         (run_o),
    .tx_iq_o       (tx_iq_o),
    .tx_iq_valid_o (tx_iq_valid_o),
    .tx_iq_ready_i (tx_iq_ready_i)
  );

  // Status echo follows the decoded commands
  us_frame_builder builder0 (
    .clk           (clk),
    .reset         (reset),
    .run_i         (run_o),
    .cmd_addr_i    (cmd_addr_o),
    .cmd_ptt_i     (cmd_ptt_o),
    .cmd_valid_i   (cmd_valid_o),
    .rx_iq_i       (rx_iq_i),
    .rx_iq_valid_i (rx_iq_valid_i),
    .rx_iq_ready_o (rx_iq_ready_o),
    .link_o        (us_link.source)
  );

endmodule

`default_nettype wire

// File: hw/us_frame_builder.sv
// Upstream protocol-1 frame source; a started frame always runs to the end
// Mic bytes go out as zeros, the status word is the echoed command and frame count
`timescale 1ns/100ps
`default_nettype none
`include "juice_settings.svh"

module us_frame_builder (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        run_i,
  input  wire hpsdr_frame_pkg::cmd_addr_t cmd_addr_i,
  input  wire                        cmd_ptt_i,
  input  wire                        cmd_valid_i,
  input  wire hpsdr_frame_pkg::rx_iq_t rx_iq_i,
  input  wire                        rx_iq_valid_i,
  output logic                       rx_iq_ready_o,
  byte_link_if.source                link_o
);
  import hpsdr_frame_pkg::*;
  import juice_link_pkg::*;

  typedef logic [$clog2(`JUICE_SLOTS)-1:0] slot_idx_t;

  builder_state_e state;
  // Header and every slot are eight bytes each
  logic [2:0]     byte_idx;
  slot_idx_t      slot_cnt;
  credit_cnt_t    credit;
  frame_cnt_t     frame_cnt;
  cmd_addr_t      echo_addr;
  logic           echo_ptt;
  rx_iq_t         smp;
  logic           have_smp;
  logic [63:0]    header;
  logic [63:0]    slot_word;
  byte_t          tx_byte;
  logic           avail;
  logic           fire;
  logic           frame_end;

  assign rx_iq_ready_o = (state == BS_SAMPLE) && !have_smp;
  assign avail = (state == BS_SYNC) || (state == BS_STATUS) ||
                 ((state == BS_SAMPLE) && have_smp);
  assign fire      = avail && (credit != '0);
  assign frame_end = (state == BS_SAMPLE) && (byte_idx == 3'd7) &&
                     (slot_cnt == slot_idx_t'(`JUICE_SLOTS - 1));

  // ----------------------------------------
  // Byte select
  // ----------------------------------------
  assign header    = {{3{`JUICE_SYNC_BYTE}}, 1'b0, echo_addr, echo_ptt, frame_cnt};
  assign slot_word = {smp, 16'h0000};

  always_comb
  begin
    if (state == BS_SAMPLE)
      tx_byte = slot_word[63 - 8*byte_idx -: 8];
    else
      tx_byte = header[63 - 8*byte_idx -: 8];
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state       <= BS_IDLE;
      byte_idx    <= '0;
      slot_cnt    <= '0;
      credit      <= credit_cnt_t'(`JUICE_LINK_CREDITS);
      frame_cnt   <= '0;
      echo_addr   <= '0;
      echo_ptt    <= 1'b0;
      have_smp    <= 1'b0;
      link_o.valid <= 1'b0;
      link_o.last <= 1'b0;
    end
    else
    begin
      link_o.valid <= fire;
      link_o.last  <= fire && frame_end;
      credit       <= credit - credit_cnt_t'(fire) + credit_cnt_t'(link_o.credit);
      if (cmd_valid_i)
      begin
        echo_addr <= cmd_addr_i;
        echo_ptt  <= cmd_ptt_i;
      end
      if (rx_iq_valid_i && rx_iq_ready_o)
        have_smp <= 1'b1;
      if (fire)
        byte_idx <= byte_idx + 1'b1;
      case (state)
        BS_IDLE:
          if (run_i)
          begin
            state    <= BS_SYNC;
            byte_idx <= '0;
            slot_cnt <= '0;
          end
        BS_SYNC:
          if (fire && (byte_idx == 3'd2))
            state <= BS_STATUS;
        BS_STATUS:
          if (fire && (byte_idx == 3'd7))
            state <= BS_SAMPLE;
        BS_SAMPLE:
          if (fire && (byte_idx == 3'd7))
          begin
            have_smp <= 1'b0;
            slot_cnt <= slot_cnt + 1'b1;
            if (frame_end)
            begin
              state     <= BS_IDLE;
              frame_cnt <= frame_cnt + 1'b1;
            end
          end
        default:
          state <= BS_IDLE;
      endcase
    end
  end

  // Sample capture
  always_ff @(posedge clk)
  begin
    link_o.data <= tx_byte;
    if (rx_iq_valid_i && rx_iq_ready_o)
      smp <= rx_iq_i;
  end

  // Phy never hands back more credits than were spent
  a_credit_max: assert property (@(posedge clk) disable iff (reset)
    credit <= credit_cnt_t'(`JUICE_LINK_CREDITS));

endmodule

`default_nettype wire

// File: hw/ds_frame_parser.sv
// Downstream protocol-1 decoder; audio bytes of each slot are dropped
// A pending tx_iq word stalls the byte buffer and with it the credit return
`timescale 1ns/100ps
`default_nettype none
`include "juice_settings.svh"

module ds_frame_parser (
  input  wire                        clk,
  input  wire                        reset,
  byte_link_if.sink                  link_i,
  output hpsdr_frame_pkg::cmd_addr_t cmd_addr_o,
  output hpsdr_frame_pkg::cmd_data_t cmd_data_o,
  output logic                       cmd_ptt_o,
  output logic                       cmd_valid_o,
  output logic                       run_o,
  output hpsdr_frame_pkg::tx_iq_t    tx_iq_o,
  output logic                       tx_iq_valid_o,
  input  wire                        tx_iq_ready_i
);
  import hpsdr_frame_pkg::*;
  import juice_link_pkg::*;

  typedef logic [$clog2(`JUICE_FRAME_BYTES)-1:0] frame_pos_t;

  parser_state_e state;
  // Byte index within the frame, sync bytes are 0 to 2
  frame_pos_t    pos;
  byte_t         buf_mem [`JUICE_LINK_CREDITS];
  logic [$clog2(`JUICE_LINK_CREDITS)-1:0] wr_ptr;
  logic [$clog2(`JUICE_LINK_CREDITS)-1:0] rd_ptr;
  credit_cnt_t   cnt;
  byte_t         cur;
  logic          pop;
  cmd_addr_t     c0_addr;
  logic          c0_ptt;
  logic [23:0]   c_data;
  logic [23:0]   iq_part;

  assign cur = buf_mem[rd_ptr];
  assign pop = (cnt != '0) && !(tx_iq_valid_o && !tx_iq_ready_i);

  // ----------------------------------------
  // Frame sequencing
  // ----------------------------------------
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state         <= PS_HUNT;
      pos           <= '0;
      cnt           <= '0;
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      link_i.credit <= 1'b0;
      cmd_valid_o   <= 1'b0;
      run_o         <= 1'b0;
      tx_iq_valid_o <= 1'b0;
    end
    else
    begin
      cnt           <= cnt + credit_cnt_t'(link_i.valid) - credit_cnt_t'(pop);
      link_i.credit <= pop;
      cmd_valid_o   <= 1'b0;
      if (link_i.valid)
        wr_ptr <= wr_ptr + 1'b1;
      if (tx_iq_ready_i)
        tx_iq_valid_o <= 1'b0;
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
        case (state)
          PS_HUNT:
            if (cur == `JUICE_SYNC_BYTE)
            begin
              state <= PS_SYNC;
              pos   <= frame_pos_t'(1);
            end
          PS_SYNC:
            if (cur != `JUICE_SYNC_BYTE)
              state <= PS_HUNT;
            else
            begin
              pos <= pos + 1'b1;
              if (pos == frame_pos_t'(2))
                state <= PS_CTRL;
            end
          PS_CTRL:
          begin
            pos <= pos + 1'b1;
            // C4 completes the command
            if (pos == frame_pos_t'(7))
            begin
              state       <= PS_SLOT;
              cmd_valid_o <= 1'b1;
              if (c0_addr == `JUICE_RUN_ADDR)
                run_o <= cur[0];
            end
          end
          PS_SLOT:
          begin
            pos <= pos + 1'b1;
            if (pos[2:0] == 3'd7)
              tx_iq_valid_o <= 1'b1;
            if (pos == frame_pos_t'(`JUICE_FRAME_BYTES - 1))
              state <= PS_HUNT;
          end
          default:
            state <= PS_HUNT;
        endcase
      end
    end
  end

  // ----------------------------------------
  // Byte buffer and field assembly
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (link_i.valid)
      buf_mem[wr_ptr] <= link_i.data;
    if (pop && (state == PS_CTRL))
    begin
      if (pos == frame_pos_t'(3))
      begin
        c0_addr <= cur[6:1];
        c0_ptt  <= cur[0];
      end
      else if (pos == frame_pos_t'(7))
      begin
        cmd_addr_o <= c0_addr;
        cmd_ptt_o  <= c0_ptt;
        cmd_data_o <= {c_data, cur};
      end
      else
        c_data <= {c_data[15:0], cur};
    end
    // Only the last three shifted bytes survive, so audio falls out
    if (pop && (state == PS_SLOT))
    begin
      if (pos[2:0] == 3'd7)
        tx_iq_o <= {iq_part, cur};
      else
        iq_part <= {iq_part[15:0], cur};
    end
  end

  a_tx_iq_hold: assert property (@(posedge clk) disable iff (reset)
    tx_iq_valid_o && !tx_iq_ready_i |=> tx_iq_valid_o && $stable(tx_iq_o));

endmodule

`default_nettype wire

// File: hw/ftdi_phy.sv
// FT245 synchronous FIFO master on clk; tristate of the data pins lives in the board wrapper
// Bursts are capped at JUICE_LINK_CREDITS bytes so reads and writes alternate
`timescale 1ns/100ps
`default_nettype none
`include "juice_settings.svh"

module ftdi_phy (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   rxf_empty_i,
  input  wire                   txf_full_i,
  input  wire juice_link_pkg::byte_t data_i,
  output juice_link_pkg::byte_t data_o,
  output logic                  data_oe_o,
  output logic                  oe_n_o,
  output logic                  rd_n_o,
  output logic                  wr_n_o,
  output logic                  siwu_n_o,
  byte_link_if.source           ds_o,
  byte_link_if.sink             us_i
);
  import juice_link_pkg::*;

  phy_state_e  state;
  phy_state_e  state_nxt;
  credit_cnt_t ds_credit;
  credit_cnt_t ds_credit_nxt;
  credit_cnt_t us_cnt;
  credit_cnt_t us_cnt_nxt;
  credit_cnt_t burst_cnt;
  logic [$clog2(`JUICE_LINK_CREDITS)-1:0] us_wr_ptr;
  logic [$clog2(`JUICE_LINK_CREDITS)-1:0] us_rd_ptr;
  byte_t       us_mem [`JUICE_LINK_CREDITS];
  logic        us_last_mem [`JUICE_LINK_CREDITS];
  logic        last_rd;
  logic        rd_ok;
  logic        wr_ok;
  logic        rd_fire;
  logic        wr_fire;
  logic        burst_end;

  // ----------------------------------------
  // Transfer qualifiers
  // ----------------------------------------
  assign rd_fire   = (state == PHY_RD) && !rxf_empty_i;
  assign wr_fire   = (state == PHY_WR) && !txf_full_i;
  assign rd_ok     = !rxf_empty_i && (ds_credit != '0);
  assign wr_ok     = !txf_full_i && (us_cnt != '0);
  assign burst_end = burst_cnt == credit_cnt_t'(`JUICE_LINK_CREDITS - 1);

  assign ds_credit_nxt = ds_credit - credit_cnt_t'(rd_fire) + credit_cnt_t'(ds_o.credit);
  assign us_cnt_nxt    = us_cnt - credit_cnt_t'(wr_fire) + credit_cnt_t'(us_i.valid);

  // Pin strobes decode straight from the state
  assign rd_n_o    = (state != PHY_RD);
  assign oe_n_o    = (state != PHY_RD) && (state != PHY_RD_OE);
  assign wr_n_o    = (state != PHY_WR);
  assign data_oe_o = (state == PHY_WR);
  assign data_o    = us_mem[us_rd_ptr];

  // Downstream frame boundaries are found by the parser
  assign ds_o.last = 1'b0;

  always_comb
  begin
    state_nxt = state;
    case (state)
      PHY_IDLE, PHY_TURN:
      begin
        // Favour the direction that did not run last
        if (rd_ok && !(wr_ok && last_rd))
          state_nxt = PHY_RD_OE;
        else if (wr_ok)
          state_nxt = PHY_WR;
        else
          state_nxt = PHY_IDLE;
      end
      PHY_RD_OE:
        state_nxt = PHY_RD;
      PHY_RD:
        if (rxf_empty_i || (ds_credit_nxt == '0) || burst_end)
          state_nxt = PHY_TURN;
      PHY_WR:
        if (txf_full_i || (us_cnt_nxt == '0) || burst_end)
          state_nxt = PHY_TURN;
      default:
        state_nxt = PHY_IDLE;
    endcase
  end

  // ----------------------------------------
  // Control state
  // ----------------------------------------
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state       <= PHY_IDLE;
      ds_credit   <= credit_cnt_t'(`JUICE_LINK_CREDITS);
      us_cnt      <= '0;
      burst_cnt   <= '0;
      us_wr_ptr   <= '0;
      us_rd_ptr   <= '0;
      last_rd     <= 1'b0;
      ds_o.valid  <= 1'b0;
      us_i.credit <= 1'b0;
      siwu_n_o    <= 1'b1;
    end
    else
    begin
      state       <= state_nxt;
      ds_credit   <= ds_credit_nxt;
      us_cnt      <= us_cnt_nxt;
      ds_o.valid  <= rd_fire;
      us_i.credit <= wr_fire;
      // Flush the chip buffer once a whole frame is in
      siwu_n_o    <= !(wr_fire && us_last_mem[us_rd_ptr]);
      if (us_i.valid)
        us_wr_ptr <= us_wr_ptr + 1'b1;
      if (wr_fire)
        us_rd_ptr <= us_rd_ptr + 1'b1;
      if (state == PHY_RD)
        last_rd <= 1'b1;
      else if (state == PHY_WR)
        last_rd <= 1'b0;
      if (state != state_nxt)
        burst_cnt <= '0;
      else if (rd_fire || wr_fire)
        burst_cnt <= burst_cnt + 1'b1;
    end
  end

  // Read data capture and upstream buffer
  always_ff @(posedge clk)
  begin
    ds_o.data <= data_i;
    if (us_i.valid)
    begin
      us_mem[us_wr_ptr]      <= us_i.data;
      us_last_mem[us_wr_ptr] <= us_i.last;
    end
  end

  // Reads only happen with a downstream credit in hand
  a_rd_credit: assert property (@(posedge clk) disable iff (reset)
    !rd_n_o |-> (ds_credit != '0));

  // Parser never returns more credits than it was given
  a_ds_credit_max: assert property (@(posedge clk) disable iff (reset)
    ds_credit <= credit_cnt_t'(`JUICE_LINK_CREDITS));

endmodule

`default_nettype wire

// File: hw/byte_link_if.sv
// Credit-based byte link, one byte per valid cycle
// Source spends one credit per byte, sink returns one per byte it consumes
`timescale 1ns/100ps
`default_nettype none

interface byte_link_if;
  import juice_link_pkg::*;

  byte_t data;
  logic  valid;
  // Final byte of a frame
  logic  last;
  // One-cycle pulse per freed buffer entry
  logic  credit;

  modport source (
    output data, valid, last,
    input  credit
  );

  modport sink (
    input  data, valid, last,
    output credit
  );

endinterface

`default_nettype wire

// File: hw/hpsdr_frame_pkg.sv
// OpenHPSDR protocol-1 types for the downstream parser and upstream builder
`default_nettype none

package hpsdr_frame_pkg;

  // Register command fields from C0 to C4
  typedef logic [5:0]  cmd_addr_t;
  typedef logic [31:0] cmd_data_t;

  // Transmit word, I then Q, 16 bits each
  typedef logic [31:0] tx_iq_t;

  // Receive word, I then Q, 24 bits each
  typedef logic [47:0] rx_iq_t;

  typedef logic [31:0] frame_cnt_t;

  typedef enum logic [1:0] {
    PS_HUNT,
    PS_SYNC,
    PS_CTRL,
    PS_SLOT
  } parser_state_e;

  typedef enum logic [1:0] {
    BS_IDLE,
    BS_SYNC,
    BS_STATUS,
    BS_SAMPLE
  } builder_state_e;

endpackage

`default_nettype wire

// File: hw/juice_link_pkg.sv
// Byte link and FIFO chip phy types
`default_nettype none

package juice_link_pkg;

  typedef logic [7:0] byte_t;

  // Holds 0 to JUICE_LINK_CREDITS
  typedef logic [2:0] credit_cnt_t;

  typedef enum logic [2:0] {
    PHY_IDLE,
    PHY_RD_OE,
    PHY_RD,
    PHY_WR,
    PHY_TURN
  } phy_state_e;

endpackage

`default_nettype wire

// File: hw/juice_settings.svh
// Frame geometry and link depth shared by the host-link blocks
// A frame is 8 header bytes plus JUICE_SLOTS slots of 8 bytes
`ifndef JUICE_SETTINGS_SVH
`define JUICE_SETTINGS_SVH

// Bytes per frame, same in both directions
`define JUICE_FRAME_BYTES 512

// Sample slots after sync and C0 to C4
`define JUICE_SLOTS 63

// Repeated three times at the start of every frame
`define JUICE_SYNC_BYTE 8'h7F

// Command address whose data bit 0 is the run flag
`define JUICE_RUN_ADDR 6'd0

// Initial credits and receive buffer depth, a power of two
`define JUICE_LINK_CREDITS 4

`endif
